// File: design/rv_core_pkg.sv
// rv32i core package: widths, opcodes, alu operations and pipeline control codes.
`default_nettype none

package rv_core_pkg;

    localparam int XLEN       = 32;
    localparam int NUM_REGS   = 32;
    localparam int REG_ADDR_W = $clog2(NUM_REGS);

    typedef logic [XLEN-1:0]       word_t;     // data word or instruction address.
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;
    typedef logic [3:0]            alu_op_t;
    typedef logic [1:0]            pc_ctrl_t;
    typedef logic                  pipe_ctrl_t;

    // major opcodes, instr[6:0].
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;

    localparam alu_op_t ALU_ADD    = 4'd0;
    localparam alu_op_t ALU_SUB    = 4'd1;
    localparam alu_op_t ALU_SLL    = 4'd2;
    localparam alu_op_t ALU_SLT    = 4'd3;
    localparam alu_op_t ALU_SLTU   = 4'd4;
    localparam alu_op_t ALU_XOR    = 4'd5;
    localparam alu_op_t ALU_SRL    = 4'd6;
    localparam alu_op_t ALU_SRA    = 4'd7;
    localparam alu_op_t ALU_OR     = 4'd8;
    localparam alu_op_t ALU_AND    = 4'd9;
    localparam alu_op_t ALU_PASS_B = 4'd10;  // lui.

    // kind of next address after the instruction.
    localparam pc_ctrl_t PC_NEXT   = 2'd0;
    localparam pc_ctrl_t PC_BRANCH = 2'd1;
    localparam pc_ctrl_t PC_JAL    = 2'd2;
    localparam pc_ctrl_t PC_JALR   = 2'd3;

    // command to the decode-to-execute register.
    localparam pipe_ctrl_t PIPE_CONTINUE = 1'b0;
    localparam pipe_ctrl_t PIPE_FLUSH    = 1'b1;

endpackage

`default_nettype wire

// File: design/stage_if.sv
// decoded instruction bundle passed from one pipeline stage to the next.
`timescale 1ns/1ps
`default_nettype none

interface stage_if;

    logic                  valid;
    rv_core_pkg::word_t    pc;
    rv_core_pkg::word_t    operand_a;
    rv_core_pkg::word_t    operand_b;
    rv_core_pkg::word_t    imm;
    rv_core_pkg::reg_addr_t rd;
    logic                  reg_write;   // low for x0 and for non-writing instructions.
    rv_core_pkg::alu_op_t  alu_op;
    rv_core_pkg::pc_ctrl_t pc_ctrl;
    logic [2:0]            funct3;      // branch condition.

    modport producer (
        output valid,
        output pc,
        output operand_a,
        output operand_b,
        output imm,
        output rd,
        output reg_write,
        output alu_op,
        output pc_ctrl,
        output funct3
    );

    modport consumer (
        input valid,
        input pc,
        input operand_a,
        input operand_b,
        input imm,
        input rd,
        input reg_write,
        input alu_op,
        input pc_ctrl,
        input funct3
    );

endinterface

`default_nettype wire

// File: design/instr_decode.sv
// decode stage: field split, immediates, control decode, register read and forwarding.
`timescale 1ns/1ps
`default_nettype none

module instr_decode (
    input  logic                   clk_i,
    input  logic                   instr_valid_i,
    input  rv_core_pkg::word_t     instr_i,
    input  rv_core_pkg::word_t     pc_i,
    output rv_core_pkg::reg_addr_t rs1_addr_o,
    output rv_core_pkg::reg_addr_t rs2_addr_o,
    input  rv_core_pkg::word_t     rs1_data_i,
    input  rv_core_pkg::word_t     rs2_data_i,
    input  rv_core_pkg::reg_addr_t fwd_rd_i,
    input  logic                   fwd_write_i,
    input  rv_core_pkg::word_t     fwd_data_i,
    stage_if.producer              dec_o
);

    logic [6:0]             opcode;
    logic [2:0]             funct3;
    logic                   alt;       // instr[30], sub and sra select.
    rv_core_pkg::reg_addr_t rd;
    rv_core_pkg::word_t     imm_i, imm_u, imm_b, imm_j;
    rv_core_pkg::word_t     rs1_val, rs2_val;
    rv_core_pkg::word_t     imm, op_a, op_b;
    rv_core_pkg::alu_op_t   alu_op;
    rv_core_pkg::pc_ctrl_t  pc_ctrl;
    logic                   writes;

    // funct3 to alu operation, shared by op and op-imm.
    function automatic rv_core_pkg::alu_op_t alu_sel(input logic [2:0] f3, input logic sel_alt);
        rv_core_pkg::alu_op_t op;
        case (f3)
            3'b000:  op = sel_alt ? rv_core_pkg::ALU_SUB : rv_core_pkg::ALU_ADD;
            3'b001:  op = rv_core_pkg::ALU_SLL;
            3'b010:  op = rv_core_pkg::ALU_SLT;
            3'b011:  op = rv_core_pkg::ALU_SLTU;
            3'b100:  op = rv_core_pkg::ALU_XOR;
            3'b101:  op = sel_alt ? rv_core_pkg::ALU_SRA : rv_core_pkg::ALU_SRL;
            3'b110:  op = rv_core_pkg::ALU_OR;
            default: op = rv_core_pkg::ALU_AND;
        endcase
        return op;
    endfunction

    assign opcode     = instr_i[6:0];
    assign rd         = instr_i[11:7];
    assign funct3     = instr_i[14:12];
    assign alt        = instr_i[30];
    assign rs1_addr_o = instr_i[19:15];
    assign rs2_addr_o = instr_i[24:20];

    assign imm_i = {{20{instr_i[31]}}, instr_i[31:20]};
    assign imm_u = {instr_i[31:12], 12'b0};
    assign imm_b = {{19{instr_i[31]}}, instr_i[31], instr_i[7], instr_i[30:25],
                    instr_i[11:8], 1'b0};
    assign imm_j = {{11{instr_i[31]}}, instr_i[31], instr_i[19:12], instr_i[20],
                    instr_i[30:21], 1'b0};

    // the instruction in execute wins over the register file.
    assign rs1_val = (fwd_write_i && fwd_rd_i == rs1_addr_o) ? fwd_data_i : rs1_data_i;
    assign rs2_val = (fwd_write_i && fwd_rd_i == rs2_addr_o) ? fwd_data_i : rs2_data_i;

    always_comb begin
        writes  = 1'b0;
        alu_op  = rv_core_pkg::ALU_ADD;
        pc_ctrl = rv_core_pkg::PC_NEXT;
        imm     = '0;
        op_a    = rs1_val;
        op_b    = rs2_val;
        case (opcode)
            rv_core_pkg::OPC_OP: begin
                writes = 1'b1;
                alu_op = alu_sel(funct3, alt);
            end
            rv_core_pkg::OPC_OP_IMM: begin
                writes = 1'b1;
                imm    = imm_i;
                op_b   = imm_i;
                alu_op = alu_sel(funct3, alt && funct3 == 3'b101); // addi has no subtract.
            end
            rv_core_pkg::OPC_LUI: begin
                writes = 1'b1;
                imm    = imm_u;
                op_b   = imm_u;
                alu_op = rv_core_pkg::ALU_PASS_B;
            end
            rv_core_pkg::OPC_AUIPC: begin
                writes = 1'b1;
                imm    = imm_u;
                op_a   = pc_i;
                op_b   = imm_u;
            end
            rv_core_pkg::OPC_JAL: begin
                writes  = 1'b1;
                imm     = imm_j;
                pc_ctrl = rv_core_pkg::PC_JAL;
            end
            rv_core_pkg::OPC_JALR: begin
                writes  = 1'b1;
                imm     = imm_i;
                pc_ctrl = rv_core_pkg::PC_JALR;
            end
            rv_core_pkg::OPC_BRANCH: begin
                imm     = imm_b;
                pc_ctrl = rv_core_pkg::PC_BRANCH;
            end
            default: ; // unsupported opcode is a no-op.
        endcase
    end

    assign dec_o.valid     = instr_valid_i;
    assign dec_o.pc        = pc_i;
    assign dec_o.operand_a = op_a;
    assign dec_o.operand_b = op_b;
    assign dec_o.imm       = imm;
    assign dec_o.rd        = rd;
    assign dec_o.reg_write = instr_valid_i && writes && rd != '0;
    assign dec_o.alu_op    = alu_op;
    assign dec_o.pc_ctrl   = pc_ctrl;
    assign dec_o.funct3    = funct3;

    a_no_x0_write: assert property (@(posedge clk_i)
        dec_o.valid |-> !(dec_o.reg_write && dec_o.rd == '0));

endmodule

`default_nettype wire

// File: design/pipe_decode.sv
// decode-to-execute pipeline register with continue and flush.
`timescale 1ns/1ps
`default_nettype none

module pipe_decode (
    input  logic                    clk_i,
    input  logic                    reset_i,
    input  rv_core_pkg::pipe_ctrl_t pipeline_control_i,
    stage_if.consumer               dec_i,
    stage_if.producer               exe_o
);

    logic flush;

    assign flush = reset_i || pipeline_control_i == rv_core_pkg::PIPE_FLUSH;

    // control fields, cleared by flush and reset.
    always_ff @(posedge clk_i) begin
        if (flush) begin
            exe_o.valid     <= 1'b0;
            exe_o.reg_write <= 1'b0;
            exe_o.pc_ctrl   <= rv_core_pkg::PC_NEXT;
        end else begin
            exe_o.valid     <= dec_i.valid;
            exe_o.reg_write <= dec_i.reg_write;
            exe_o.pc_ctrl   <= dec_i.pc_ctrl;
        end
    end

    // payload only moves on continue.
    always_ff @(posedge clk_i) begin
        if (!flush) begin
            exe_o.pc        <= dec_i.pc;
            exe_o.operand_a <= dec_i.operand_a;
            exe_o.operand_b <= dec_i.operand_b;
            exe_o.imm       <= dec_i.imm;
            exe_o.rd        <= dec_i.rd;
            exe_o.alu_op    <= dec_i.alu_op;
            exe_o.funct3    <= dec_i.funct3;
        end
    end

    // a squashed instruction must not reach execute.
    a_flush_kills: assert property (@(posedge clk_i)
        pipeline_control_i == rv_core_pkg::PIPE_FLUSH |=> !exe_o.valid);

endmodule

`default_nettype wire

// File: design/alu_execute.sv
// execute stage: alu, branch compare and jump target.
`timescale 1ns/1ps
`default_nettype none

module alu_execute (
    stage_if.consumer               exe_i,
    output rv_core_pkg::pipe_ctrl_t pipeline_control_o,
    output rv_core_pkg::reg_addr_t  fwd_rd_o,
    output logic                    fwd_write_o,
    output rv_core_pkg::word_t      fwd_data_o,
    output logic                    wb_en_o,
    output rv_core_pkg::reg_addr_t  wb_rd_o,
    output rv_core_pkg::word_t      wb_data_o,
    output logic                    redirect_o,
    output rv_core_pkg::word_t      redirect_target_o
);

    rv_core_pkg::word_t a, b;
    rv_core_pkg::word_t alu_result, result;
    logic [4:0]         shamt;
    logic               lt_s, lt_u, eq;
    logic               is_jump, cond, taken;

    assign a     = exe_i.operand_a;
    assign b     = exe_i.operand_b;
    assign shamt = b[4:0];
    assign lt_s  = $signed(a) < $signed(b);
    assign lt_u  = a < b;
    assign eq    = a == b;

    always_comb begin
        case (exe_i.alu_op)
            rv_core_pkg::ALU_ADD:    alu_result = a + b;
            rv_core_pkg::ALU_SUB:    alu_result = a - b;
            rv_core_pkg::ALU_SLL:    alu_result = a << shamt;
            rv_core_pkg::ALU_SLT:    alu_result = {{(rv_core_pkg::XLEN-1){1'b0}}, lt_s};
            rv_core_pkg::ALU_SLTU:   alu_result = {{(rv_core_pkg::XLEN-1){1'b0}}, lt_u};
            rv_core_pkg::ALU_XOR:    alu_result = a ^ b;
            rv_core_pkg::ALU_SRL:    alu_result = a >> shamt;
            rv_core_pkg::ALU_SRA:    alu_result = $signed(a) >>> shamt;
            rv_core_pkg::ALU_OR:     alu_result = a | b;
            rv_core_pkg::ALU_AND:    alu_result = a & b;
            rv_core_pkg::ALU_PASS_B: alu_result = b;
            default:                 alu_result = '0;
        endcase
    end

    always_comb begin
        case (exe_i.funct3)
            3'b000:  cond = eq;     // beq.
            3'b001:  cond = !eq;    // bne.
            3'b100:  cond = lt_s;   // blt.
            3'b101:  cond = !lt_s;  // bge.
            3'b110:  cond = lt_u;   // bltu.
            3'b111:  cond = !lt_u;  // bgeu.
            default: cond = 1'b0;
        endcase
    end

    assign is_jump = exe_i.pc_ctrl == rv_core_pkg::PC_JAL || exe_i.pc_ctrl == rv_core_pkg::PC_JALR;
    assign taken   = exe_i.valid &&
                     (is_jump || (exe_i.pc_ctrl == rv_core_pkg::PC_BRANCH && cond));
    assign result  = is_jump ? exe_i.pc + 32'd4 : alu_result; // link address.

    assign redirect_o        = taken;
    assign redirect_target_o = (exe_i.pc_ctrl == rv_core_pkg::PC_JALR) ?
                               ((a + exe_i.imm) & ~32'd1) : exe_i.pc + exe_i.imm;
    assign pipeline_control_o = taken ? rv_core_pkg::PIPE_FLUSH : rv_core_pkg::PIPE_CONTINUE;

    assign wb_en_o     = exe_i.valid && exe_i.reg_write;
    assign wb_rd_o     = exe_i.rd;
    assign wb_data_o   = result;
    assign fwd_write_o = exe_i.valid && exe_i.reg_write;
    assign fwd_rd_o    = exe_i.rd;
    assign fwd_data_o  = result;

endmodule

`default_nettype wire

// File: design/reg_result.sv
// result stage: register file with write-back and redirect report registers.
`timescale 1ns/1ps
`default_nettype none

module reg_result (
    input  logic                   clk_i,
    input  logic                   reset_i,
    input  logic                   wb_en_i,
    input  rv_core_pkg::reg_addr_t wb_rd_i,
    input  rv_core_pkg::word_t     wb_data_i,
    input  logic                   redirect_i,
    input  rv_core_pkg::word_t     redirect_target_i,
    input  rv_core_pkg::reg_addr_t rs1_addr_i,
    input  rv_core_pkg::reg_addr_t rs2_addr_i,
    output rv_core_pkg::word_t     rs1_data_o,
    output rv_core_pkg::word_t     rs2_data_o,
    output logic                   wb_valid_o,
    output rv_core_pkg::reg_addr_t wb_rd_o,
    output rv_core_pkg::word_t     wb_data_o,
    output logic                   redirect_valid_o,
    output rv_core_pkg::word_t     redirect_pc_o
);

    rv_core_pkg::word_t regs [1:rv_core_pkg::NUM_REGS-1]; // x0 is not stored.

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            for (int i = 1; i < rv_core_pkg::NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_en_i && wb_rd_i != '0) begin
            regs[wb_rd_i] <= wb_data_i;
        end
    end

    assign rs1_data_o = (rs1_addr_i == '0) ? '0 : regs[rs1_addr_i];
    assign rs2_data_o = (rs2_addr_i == '0) ? '0 : regs[rs2_addr_i];

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            wb_valid_o       <= 1'b0;
            redirect_valid_o <= 1'b0;
        end else begin
            wb_valid_o       <= wb_en_i;
            redirect_valid_o <= redirect_i;
        end
    end

    always_ff @(posedge clk_i) begin
        wb_rd_o       <= wb_rd_i;
        wb_data_o     <= wb_data_i;
        redirect_pc_o <= redirect_target_i;
    end

    // decode keeps x0 out of every write-back.
    a_x0_never_written: assert property (@(posedge clk_i) disable iff (reset_i)
        wb_en_i |-> wb_rd_i != '0);

endmodule

`default_nettype wire

// File: design/rv_core_top.sv
// rv32i integer pipeline top: decode, decode-to-execute register, execute, result.
`timescale 1ns/1ps
`default_nettype none

module rv_core_top (
    input  logic                   clk_i,
    input  logic                   reset_i,
    input  logic                   instr_valid_i,
    input  rv_core_pkg::word_t     instr_i,
    input  rv_core_pkg::word_t     pc_i,
    output logic                   wb_valid_o,
    output rv_core_pkg::reg_addr_t wb_rd_o,
    output rv_core_pkg::word_t     wb_data_o,
    output logic                   redirect_valid_o,
    output rv_core_pkg::word_t     redirect_pc_o
);

    rv_core_pkg::reg_addr_t  rs1_addr, rs2_addr, fwd_rd, wb_rd;
    rv_core_pkg::word_t      rs1_data, rs2_data, fwd_data, wb_data, redirect_target;
    logic                    fwd_write, wb_en, redirect;
    rv_core_pkg::pipe_ctrl_t pipe_ctrl;

    stage_if dec_bus ();
    stage_if exe_bus ();

    instr_decode u_decode (
        .clk_i, .instr_valid_i, .instr_i, .pc_i,
        .rs1_addr_o (rs1_addr),  .rs2_addr_o (rs2_addr),
        .rs1_data_i (rs1_data),  .rs2_data_i (rs2_data),
        .fwd_rd_i   (fwd_rd),    .fwd_write_i (fwd_write), .fwd_data_i (fwd_data),
        .dec_o      (dec_bus)
    );

    pipe_decode u_pipe (
        .clk_i, .reset_i,
        .pipeline_control_i (pipe_ctrl),
        .dec_i (dec_bus),
        .exe_o (exe_bus)
    );

    alu_execute u_execute (
        .exe_i (exe_bus), .pipeline_control_o (pipe_ctrl),
        .fwd_rd_o (fwd_rd), .fwd_write_o (fwd_write), .fwd_data_o (fwd_data),
        .wb_en_o (wb_en), .wb_rd_o (wb_rd), .wb_data_o (wb_data),
        .redirect_o (redirect), .redirect_target_o (redirect_target)
    );

    reg_result u_result (
        .clk_i, .reset_i,
        .wb_en_i (wb_en), .wb_rd_i (wb_rd), .wb_data_i (wb_data),
        .redirect_i (redirect), .redirect_target_i (redirect_target),
        .rs1_addr_i (rs1_addr), .rs2_addr_i (rs2_addr),
        .rs1_data_o (rs1_data), .rs2_data_o (rs2_data),
        .wb_valid_o, .wb_rd_o, .wb_data_o, .redirect_valid_o, .redirect_pc_o
    );

endmodule

`default_nettype wire

// File: dv/rv_core_tests.svh
// directed tests for the rv32i pipeline, included by the testbench module.

    // outputs stay quiet after reset.
    task automatic reset_quiet();
        idle_cycles(4);
    endtask

    // every alu operation on fixed then random operands, with gaps.
    task automatic alu_ops();
        rv_core_pkg::word_t a, b;
        logic [11:0]        imm;
        logic [4:0]         shamt;
        for (int it = 0; it < 4; it++) begin
            a = (it == 0) ? 32'hffff_fff0 : $urandom;  // first pass splits slt from sltu.
            b = (it == 0) ? 32'h0000_0003 : $urandom;
            load_reg(5'd1, a);
            load_reg(5'd2, b);
            for (int f3 = 0; f3 < 8; f3++) begin
                issue(r_type(7'h00, 5'd2, 5'd1, 3'(f3), 5'd3));
                idle_cycles(1);
                if (f3 == 0 || f3 == 5) begin
                    issue(r_type(7'h20, 5'd2, 5'd1, 3'(f3), 5'd3));  // sub and sra.
                    idle_cycles(1);
                end
            end
            for (int f3 = 0; f3 < 8; f3++) begin
                imm   = 12'($urandom);
                shamt = 5'($urandom);
                if (f3 == 1 || f3 == 5) begin
                    imm = {7'h00, shamt};
                end
                issue(i_type(imm, 5'd1, 3'(f3), 5'd4, rv_core_pkg::OPC_OP_IMM));
                idle_cycles(1);
            end
            issue(i_type({7'h20, shamt}, 5'd1, 3'd5, 5'd4, rv_core_pkg::OPC_OP_IMM));
            idle_cycles(1);
            issue(u_type(20'($urandom), 5'd6, rv_core_pkg::OPC_AUIPC));
            idle_cycles(1);
        end
    endtask

    // back-to-back readers of the previous result.
    task automatic forward_chain();
        load_reg(5'd5, $urandom);
        issue(i_type(12'h123, 5'd5, 3'd0, 5'd6, rv_core_pkg::OPC_OP_IMM));
        issue(r_type(7'h00, 5'd5, 5'd6, 3'd0, 5'd7));  // x6 forwarded.
        issue(r_type(7'h20, 5'd6, 5'd7, 3'd0, 5'd8));  // x6 now two behind.
        issue(r_type(7'h00, 5'd5, 5'd8, 3'd4, 5'd9));  // x8 forwarded, x5 from the file.
        repeat (5) issue(i_type(12'd1, 5'd10, 3'd0, 5'd10, rv_core_pkg::OPC_OP_IMM));
        idle_cycles(2);
    endtask

    task automatic x0_writes();
        issue(i_type(12'd5, 5'd0, 3'd0, 5'd0, rv_core_pkg::OPC_OP_IMM));
        issue(r_type(7'h00, 5'd0, 5'd0, 3'd0, 5'd11));
        issue(i_type(12'd7, 5'd1, 3'd0, 5'd0, rv_core_pkg::OPC_OP_IMM));
        issue(r_type(7'h00, 5'd1, 5'd0, 3'd0, 5'd12));  // x0 must not be forwarded.
        issue(u_type(20'habcde, 5'd0, rv_core_pkg::OPC_LUI));
        idle_cycles(2);
    endtask

    // each condition on three operand pairs, so each is seen taken and not taken.
    task automatic branch_conditions();
        logic [4:0]  rs1, rs2;
        logic [12:0] off;
        load_reg(5'd13, 32'hffff_fffb);
        load_reg(5'd14, 32'h0000_0003);
        for (int f3 = 0; f3 < 8; f3++) begin
            if (f3 == 2 || f3 == 3) begin
                continue;
            end
            for (int p = 0; p < 3; p++) begin
                rs1 = (p == 1) ? 5'd14 : 5'd13;
                rs2 = (p == 0) ? 5'd14 : 5'd13;
                off = 13'($urandom_range(0, 4095) * 2);
                issue(b_type(off, rs2, rs1, 3'(f3)));
                issue(i_type(12'(f3 * 3 + p + 1), 5'd0, 3'd0, 5'd15, rv_core_pkg::OPC_OP_IMM));
                idle_cycles(2);
            end
        end
        // a taken branch right behind a taken branch never resolves.
        issue(b_type(13'd16, 5'd13, 5'd13, 3'd0));
        issue(b_type(13'd32, 5'd13, 5'd13, 3'd0));
        issue(b_type(13'h1ff0, 5'd13, 5'd13, 3'd0));
        idle_cycles(2);
    endtask

    task automatic jump_links();
        issue(j_type(21'h000800, 5'd16));
        issue(i_type(12'd1, 5'd0, 3'd0, 5'd17, rv_core_pkg::OPC_OP_IMM));
        idle_cycles(1);
        issue(i_type(12'd6, 5'd13, 3'd0, 5'd18, rv_core_pkg::OPC_JALR));  // odd sum.
        issue(i_type(12'd2, 5'd0, 3'd0, 5'd17, rv_core_pkg::OPC_OP_IMM));
        idle_cycles(1);
        issue(i_type(12'h101, 5'd0, 3'd0, 5'd19, rv_core_pkg::OPC_OP_IMM));
        issue(i_type(12'h010, 5'd19, 3'd0, 5'd20, rv_core_pkg::OPC_JALR));  // base forwarded.
        issue(i_type(12'd3, 5'd0, 3'd0, 5'd17, rv_core_pkg::OPC_OP_IMM));
        idle_cycles(1);
        issue(j_type(21'h1ffff0, 5'd0));
        issue(i_type(12'd4, 5'd0, 3'd0, 5'd17, rv_core_pkg::OPC_OP_IMM));
        idle_cycles(2);
    endtask

    // load, system and all-ones words do nothing and squash nothing.
    task automatic unsupported_noops();
        issue(32'h0000_2283);
        issue(i_type(12'd3, 5'd21, 3'd0, 5'd21, rv_core_pkg::OPC_OP_IMM));
        idle_cycles(1);
        issue(32'h0000_0073);
        issue(i_type(12'd3, 5'd21, 3'd0, 5'd21, rv_core_pkg::OPC_OP_IMM));
        idle_cycles(1);
        issue(32'hffff_ffff);
        issue(i_type(12'd3, 5'd21, 3'd0, 5'd21, rv_core_pkg::OPC_OP_IMM));
        idle_cycles(1);
    endtask

// File: dv/rv_core_tb.sv
// rv32i pipeline testbench: clock, reset, reference model, output checks and test sequence.
`timescale 1ns/1ps
`default_nettype none

module rv_core_tb;

    localparam int RESET_CYCLES = 10;
    localparam int TEST_STEPS   = 330;  // clock steps over all tests, drain included.
    localparam int MAX_CYCLES   = RESET_CYCLES + 2 * TEST_STEPS + 50;

    // what the outputs must show for one strobe slot.
    typedef struct packed {
        logic                   wb;
        rv_core_pkg::reg_addr_t rd;
        rv_core_pkg::word_t     data;
        logic                   redirect;
        rv_core_pkg::word_t     target;
    } expect_t;

    logic                   clk_i, reset_i, instr_valid_i, wb_valid_o, redirect_valid_o;
    rv_core_pkg::word_t     instr_i, pc_i, wb_data_o, redirect_pc_o;
    rv_core_pkg::reg_addr_t wb_rd_o;

    rv_core_pkg::word_t model_regs [32];
    expect_t            pending [3];  // [2] is due at the outputs this cycle.
    rv_core_pkg::word_t cur_pc;
    logic               squash_next;  // last strobe was a taken transfer.
    int                 cycle_count;

    rv_core_top u_dut (
        .clk_i, .reset_i, .instr_valid_i, .instr_i, .pc_i,
        .wb_valid_o, .wb_rd_o, .wb_data_o, .redirect_valid_o, .redirect_pc_o
    );

    initial begin
        clk_i = 1'b0;
        forever #10 clk_i = ~clk_i;
    end

    initial begin
        cycle_count = 0;
        while (cycle_count < MAX_CYCLES) begin
            @(posedge clk_i);
            cycle_count++;
        end
        $display("run did not finish within %0d cycles, stopping", MAX_CYCLES);
        $display("TEST RESULT: FAIL");
        $fatal(1, "timeout");
    end

    task automatic check_equal(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("ERROR at %0t ns: %s is 0x%08h, expected 0x%08h",
                     $time, name, actual, expected);
            $display("TEST RESULT: FAIL");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    // rv32i integer operation, alt is instr[30] where it picks sub or sra.
    function automatic rv_core_pkg::word_t alu_ref(input logic [2:0] f3, input logic alt,
                                                   input rv_core_pkg::word_t a, b);
        case (f3)
            3'd0:    return alt ? a - b : a + b;
            3'd1:    return a << b[4:0];
            3'd2:    return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'd3:    return (a < b) ? 32'd1 : 32'd0;
            3'd4:    return a ^ b;
            3'd5: begin
                if (alt) begin
                    return $signed(a) >>> b[4:0];
                end
                return a >> b[4:0];
            end
            3'd6:    return a | b;
            default: return a & b;
        endcase
    endfunction

    // architectural reference, runs one instruction on model_regs.
    task automatic exec_model(input rv_core_pkg::word_t instr, input rv_core_pkg::word_t pc,
                              output expect_t slot);
        rv_core_pkg::word_t a, b, imm_i;
        logic               lt;
        a       = model_regs[instr[19:15]];
        b       = model_regs[instr[24:20]];
        imm_i   = {{20{instr[31]}}, instr[31:20]};
        lt      = instr[13] ? (a < b) : ($signed(a) < $signed(b));
        slot    = '0;
        slot.rd = instr[11:7];
        case (instr[6:0])
            7'b0110011: begin
                slot.wb   = 1'b1;
                slot.data = alu_ref(instr[14:12], instr[30], a, b);
            end
            7'b0010011: begin  // only srai reads instr[30].
                slot.wb   = 1'b1;
                slot.data = alu_ref(instr[14:12], instr[30] && instr[14:12] == 3'd5, a, imm_i);
            end
            7'b0110111: begin
                slot.wb   = 1'b1;
                slot.data = {instr[31:12], 12'h000};
            end
            7'b0010111: begin
                slot.wb   = 1'b1;
                slot.data = pc + {instr[31:12], 12'h000};
            end
            7'b1101111: begin
                slot.wb       = 1'b1;
                slot.data     = pc + 32'd4;
                slot.redirect = 1'b1;
                slot.target   = pc + {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
            end
            7'b1100111: begin
                slot.wb       = 1'b1;
                slot.data     = pc + 32'd4;
                slot.redirect = 1'b1;
                slot.target   = (a + imm_i) & ~32'd1;
            end
            7'b1100011: begin
                case (instr[14:13])
                    2'b00:   slot.redirect = (a == b) ^ instr[12];
                    2'b01:   slot.redirect = 1'b0;
                    default: slot.redirect = lt ^ instr[12];
                endcase
                slot.target = pc + {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
            end
            default: ;
        endcase
        if (slot.rd == '0) begin
            slot.wb = 1'b0;
        end
        if (slot.wb) begin
            model_regs[slot.rd] = slot.data;
        end
    endtask

    // one clock: drive a slot, predict it, check the slot strobed two cycles before.
    task automatic clock_step(input logic valid, input rv_core_pkg::word_t instr);
        expect_t slot;
        slot = '0;
        @(posedge clk_i);
        instr_valid_i <= valid;
        instr_i       <= instr;
        pc_i          <= cur_pc;
        if (valid && !squash_next) begin
            exec_model(instr, cur_pc, slot);
        end
        squash_next = slot.redirect;
        pending[2]  = pending[1];
        pending[1]  = pending[0];
        pending[0]  = slot;
        if (valid) begin
            cur_pc += 32'd4;
        end
        @(negedge clk_i);
        check_equal("wb_valid_o", wb_valid_o, pending[2].wb);
        if (pending[2].wb) begin
            check_equal("wb_rd_o", wb_rd_o, pending[2].rd);
            check_equal("wb_data_o", wb_data_o, pending[2].data);
        end
        check_equal("redirect_valid_o", redirect_valid_o, pending[2].redirect);
        if (pending[2].redirect) begin
            check_equal("redirect_pc_o", redirect_pc_o, pending[2].target);
        end
    endtask

    task automatic issue(input rv_core_pkg::word_t instr);
        clock_step(1'b1, instr);
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) clock_step(1'b0, '0);
    endtask

    function automatic rv_core_pkg::word_t r_type(input logic [6:0] f7,
            input logic [4:0] rs2, rs1, input logic [2:0] f3, input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, rv_core_pkg::OPC_OP};
    endfunction

    function automatic rv_core_pkg::word_t i_type(input logic [11:0] imm,
            input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd,
            input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic rv_core_pkg::word_t u_type(input logic [19:0] imm,
            input logic [4:0] rd, input logic [6:0] opc);
        return {imm, rd, opc};
    endfunction

    function automatic rv_core_pkg::word_t b_type(input logic [12:0] off,
            input logic [4:0] rs2, rs1, input logic [2:0] f3);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], rv_core_pkg::OPC_BRANCH};
    endfunction

    function automatic rv_core_pkg::word_t j_type(input logic [20:0] off, input logic [4:0] rd);
        return {off[20], off[10:1], off[11], off[19:12], rd, rv_core_pkg::OPC_JAL};
    endfunction

    // lui then addi, each followed by an idle cycle.
    task automatic load_reg(input logic [4:0] rd, input rv_core_pkg::word_t value);
        rv_core_pkg::word_t upper;
        upper = value + 32'h800;  // addi sign-extends its low half.
        issue(u_type(upper[31:12], rd, rv_core_pkg::OPC_LUI));
        idle_cycles(1);
        issue(i_type(value[11:0], rd, 3'd0, rd, rv_core_pkg::OPC_OP_IMM));
        idle_cycles(1);
    endtask

    `include "rv_core_tests.svh"

    initial begin
        void'($urandom(32'hf52d));
        reset_i       = 1'b1;
        instr_valid_i = 1'b0;
        instr_i       = '0;
        pc_i          = '0;
        cur_pc        = 32'h0000_1000;
        squash_next   = 1'b0;
        pending       = '{default: '0};
        model_regs    = '{default: '0};
        repeat (RESET_CYCLES) @(posedge clk_i);
        reset_i <= 1'b0;
        reset_quiet();
        alu_ops();
        forward_chain();
        x0_writes();
        branch_conditions();
        jump_links();
        unsupported_noops();
        idle_cycles(2);  // drain the last two strobes.
        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

`default_nettype wire

// File: src.f
+incdir+dv
design/rv_core_pkg.sv
design/stage_if.sv
design/instr_decode.sv
design/pipe_decode.sv
design/alu_execute.sv
design/reg_result.sv
design/rv_core_top.sv
dv/rv_core_tb.sv

// File: Bender.yml
package:
  name: rv_core

sources:
  - files:
      - design/rv_core_pkg.sv
      - design/stage_if.sv
      - design/instr_decode.sv
      - design/pipe_decode.sv
      - design/alu_execute.sv
      - design/reg_result.sv
      - design/rv_core_top.sv
  - target: simulation
    include_dirs:
      - dv
    files:
      - dv/rv_core_tb.sv
